// File: design/asym_fifo_pkg.sv
package asym_fifo_pkg;

  // default port widths and narrow-side address width
  // 32-bit write, 8-bit read, 32 narrow units of storage
  parameter int DEF_W_DATA_W = 32;
  parameter int DEF_R_DATA_W = 8;
  parameter int DEF_ADDR_W = 5;

  // wider of the two port widths
  function automatic int asym_max(input int a, input int b);
    if (a > b) begin
      return a;
    end
    return b;
  endfunction

  // narrower of the two port widths, the unit of level counting
  function automatic int asym_min(input int a, input int b);
    if (a < b) begin
      return a;
    end
    return b;
  endfunction

  // number of address bits that pick a bank
  // ratio is assumed to be a power of two
  function automatic int asym_ratio_log2(input int a, input int b);
    int ratio;
    ratio = asym_max(a, b) / asym_min(a, b);
    return $clog2(ratio);
  endfunction

endpackage

// File: design/fifo_pointers.sv
`timescale 1ns/1ps

module fifo_pointers
  import asym_fifo_pkg::*;
#(
  parameter int W_DATA_W = DEF_W_DATA_W,
  parameter int R_DATA_W = DEF_R_DATA_W,
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic w_en_i,
  input  logic r_en_i,
  output logic wr_go_o,
  output logic rd_go_o,
  output logic [((W_DATA_W >= R_DATA_W) ?
                 (ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W)) : ADDR_W)-1:0] wr_addr_o,
  output logic [((R_DATA_W >= W_DATA_W) ?
                 (ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W)) : ADDR_W)-1:0] rd_addr_o,
  output logic w_full_o,
  output logic r_empty_o,
  output logic [ADDR_W:0] level_o
);

  localparam int MAXDATA_W = asym_max(W_DATA_W, R_DATA_W);
  localparam int MINDATA_W = asym_min(W_DATA_W, R_DATA_W);
  localparam int MINADDR_W = ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W);
  localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
  localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

  // narrow units moved by one access on each port
  localparam logic [ADDR_W:0] W_STEP = (ADDR_W + 1)'(W_DATA_W / MINDATA_W);
  localparam logic [ADDR_W:0] R_STEP = (ADDR_W + 1)'(R_DATA_W / MINDATA_W);
  // total capacity in narrow units
  localparam logic [ADDR_W:0] DEPTH = (ADDR_W + 1)'(1) << ADDR_W;

  logic [W_ADDR_W-1:0] wr_ptr_q;
  logic [R_ADDR_W-1:0] rd_ptr_q;
  logic [ADDR_W:0] level_q;
  logic [ADDR_W:0] level_d;
  logic [ADDR_W:0] free_space;
  logic full;
  logic empty;
  logic wr_go;
  logic rd_go;

  // flags come straight from the registered level
  assign free_space = DEPTH - level_q;
  assign full = (free_space < W_STEP);
  assign empty = (level_q < R_STEP);

  // requests against a flag are dropped here and nowhere else
  assign wr_go = w_en_i & ~full;
  assign rd_go = r_en_i & ~empty;

  // level update, both ports may move in the same cycle
  always_comb begin
    level_d = level_q;
    if (wr_go) begin
      level_d = level_d + W_STEP;
    end
    if (rd_go) begin
      level_d = level_d - R_STEP;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      level_q <= '0;
    end else begin
      level_q <= level_d;
    end
  end

  // write pointer counts write words, wraps over the memory
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
    end else if (wr_go) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // read pointer counts read words
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
    end else if (rd_go) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign wr_go_o = wr_go;
  assign rd_go_o = rd_go;
  assign wr_addr_o = wr_ptr_q;
  assign rd_addr_o = rd_ptr_q;
  assign w_full_o = full;
  assign r_empty_o = empty;
  assign level_o = level_q;

endmodule

// File: design/asym_converter.sv
`timescale 1ns/1ps

module asym_converter
  import asym_fifo_pkg::*;
#(
  parameter int W_DATA_W = DEF_W_DATA_W,
  parameter int R_DATA_W = DEF_R_DATA_W,
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic clk_i,
  input  logic rst_n_i,
  // write side, already gated by the pointer logic
  input  logic w_en_i,
  input  logic [((W_DATA_W >= R_DATA_W) ?
                 (ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W)) : ADDR_W)-1:0] w_addr_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  // read side
  input  logic r_en_i,
  input  logic [((R_DATA_W >= W_DATA_W) ?
                 (ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W)) : ADDR_W)-1:0] r_addr_i,
  // banked memory port
  output logic [asym_max(W_DATA_W, R_DATA_W)/asym_min(W_DATA_W, R_DATA_W)-1:0] ext_mem_w_en_o,
  output logic [ADDR_W-asym_ratio_log2(W_DATA_W, R_DATA_W)-1:0] ext_mem_w_addr_o,
  output logic [asym_max(W_DATA_W, R_DATA_W)-1:0] ext_mem_w_data_o,
  output logic [asym_max(W_DATA_W, R_DATA_W)/asym_min(W_DATA_W, R_DATA_W)-1:0] ext_mem_r_en_o,
  output logic [ADDR_W-asym_ratio_log2(W_DATA_W, R_DATA_W)-1:0] ext_mem_r_addr_o,
  input  logic [asym_max(W_DATA_W, R_DATA_W)-1:0] ext_mem_r_data_i,
  output logic [R_DATA_W-1:0] r_data_o
);

  localparam int MAXDATA_W = asym_max(W_DATA_W, R_DATA_W);
  localparam int MINDATA_W = asym_min(W_DATA_W, R_DATA_W);
  localparam int R = MAXDATA_W / MINDATA_W;
  localparam int RATIO_LOG2 = asym_ratio_log2(W_DATA_W, R_DATA_W);
  localparam int MINADDR_W = ADDR_W - RATIO_LOG2;
  localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
  localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

  logic r_valid_q;
  logic [MAXDATA_W-1:0] r_data_q;
  logic [MAXDATA_W-1:0] r_data_int;

  // memory output is fresh only the cycle after a read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= r_en_i;
    end
  end

  // keep the last word so r_data_o holds between pops
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_data_q <= '0;
    end else if (r_valid_q) begin
      r_data_q <= ext_mem_r_data_i;
    end
  end

  assign r_data_int = r_valid_q ? ext_mem_r_data_i : r_data_q;

  if (W_DATA_W > R_DATA_W) begin : g_write_wider
    logic [RATIO_LOG2-1:0] r_lsbs_q;
    logic [MAXDATA_W-1:0] r_shifted;

    // whole wide word goes into all banks at once
    assign ext_mem_w_en_o = {R{w_en_i}};
    assign ext_mem_w_addr_o = w_addr_i;
    assign ext_mem_w_data_o = w_data_i;

    // low read address bits pick the bank
    assign ext_mem_r_en_o = {{(R - 1){1'b0}}, r_en_i} << r_addr_i[RATIO_LOG2-1:0];
    assign ext_mem_r_addr_o = r_addr_i[R_ADDR_W-1:RATIO_LOG2];

    // bank select of the pop, used one cycle later for the output slice
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        r_lsbs_q <= '0;
      end else if (r_en_i) begin
        r_lsbs_q <= r_addr_i[RATIO_LOG2-1:0];
      end
    end

    assign r_shifted = r_data_int >> (r_lsbs_q * R_DATA_W);
    assign r_data_o = r_shifted[R_DATA_W-1:0];

  end else if (W_DATA_W < R_DATA_W) begin : g_read_wider
    // narrow write lands in its own bank, lsb part first
    assign ext_mem_w_en_o = {{(R - 1){1'b0}}, w_en_i} << w_addr_i[RATIO_LOG2-1:0];
    assign ext_mem_w_addr_o = w_addr_i[W_ADDR_W-1:RATIO_LOG2];
    assign ext_mem_w_data_o = {{(R_DATA_W - W_DATA_W){1'b0}}, w_data_i}
                              << (w_addr_i[RATIO_LOG2-1:0] * W_DATA_W);

    // wide read takes every bank
    assign ext_mem_r_en_o = {R{r_en_i}};
    assign ext_mem_r_addr_o = r_addr_i;
    assign r_data_o = r_data_int;

  end else begin : g_same_width
    // single bank, no conversion
    assign ext_mem_w_en_o = {R{w_en_i}};
    assign ext_mem_w_addr_o = w_addr_i;
    assign ext_mem_w_data_o = w_data_i;

    assign ext_mem_r_en_o = {R{r_en_i}};
    assign ext_mem_r_addr_o = r_addr_i;
    assign r_data_o = r_data_int;
  end

endmodule

// File: design/banked_ram.sv
`timescale 1ns/1ps

module banked_ram
  import asym_fifo_pkg::*;
#(
  parameter int W_DATA_W = DEF_W_DATA_W,
  parameter int R_DATA_W = DEF_R_DATA_W,
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic clk_i,
  input  logic [asym_max(W_DATA_W, R_DATA_W)/asym_min(W_DATA_W, R_DATA_W)-1:0] ext_mem_w_en_i,
  input  logic [ADDR_W-asym_ratio_log2(W_DATA_W, R_DATA_W)-1:0] ext_mem_w_addr_i,
  input  logic [asym_max(W_DATA_W, R_DATA_W)-1:0] ext_mem_w_data_i,
  input  logic [asym_max(W_DATA_W, R_DATA_W)/asym_min(W_DATA_W, R_DATA_W)-1:0] ext_mem_r_en_i,
  input  logic [ADDR_W-asym_ratio_log2(W_DATA_W, R_DATA_W)-1:0] ext_mem_r_addr_i,
  output logic [asym_max(W_DATA_W, R_DATA_W)-1:0] ext_mem_r_data_o
);

  localparam int MAXDATA_W = asym_max(W_DATA_W, R_DATA_W);
  localparam int MINDATA_W = asym_min(W_DATA_W, R_DATA_W);
  localparam int R = MAXDATA_W / MINDATA_W;
  localparam int MINADDR_W = ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W);
  localparam int DEPTH = 1 << MINADDR_W;

  // one narrow array per bank, bank 0 holds the lsb part
  for (genvar i = 0; i < R; i++) begin : g_bank
    logic [MINDATA_W-1:0] mem [DEPTH];
    logic [MINDATA_W-1:0] rd_q;

    always_ff @(posedge clk_i) begin
      if (ext_mem_w_en_i[i]) begin
        mem[ext_mem_w_addr_i] <= ext_mem_w_data_i[i*MINDATA_W +: MINDATA_W];
      end
    end

    // read register only moves when this bank is read
    always_ff @(posedge clk_i) begin
      if (ext_mem_r_en_i[i]) begin
        rd_q <= mem[ext_mem_r_addr_i];
      end
    end

    assign ext_mem_r_data_o[i*MINDATA_W +: MINDATA_W] = rd_q;
  end

endmodule

// File: design/asym_fifo.sv
`timescale 1ns/1ps

module asym_fifo
  import asym_fifo_pkg::*;
#(
  parameter int W_DATA_W = DEF_W_DATA_W,
  parameter int R_DATA_W = DEF_R_DATA_W,
  parameter int ADDR_W = DEF_ADDR_W
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic w_en_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  output logic w_full_o,
  input  logic r_en_i,
  output logic [R_DATA_W-1:0] r_data_o,
  output logic r_empty_o,
  output logic [ADDR_W:0] level_o
);

  localparam int MAXDATA_W = asym_max(W_DATA_W, R_DATA_W);
  localparam int MINDATA_W = asym_min(W_DATA_W, R_DATA_W);
  localparam int R = MAXDATA_W / MINDATA_W;
  localparam int MINADDR_W = ADDR_W - asym_ratio_log2(W_DATA_W, R_DATA_W);
  localparam int W_ADDR_W = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;
  localparam int R_ADDR_W = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W;

  // pointers to converter
  logic wr_go;
  logic rd_go;
  logic [W_ADDR_W-1:0] wr_addr;
  logic [R_ADDR_W-1:0] rd_addr;

  // converter to memory
  logic [R-1:0] mem_w_en;
  logic [MINADDR_W-1:0] mem_w_addr;
  logic [MAXDATA_W-1:0] mem_w_data;
  logic [R-1:0] mem_r_en;
  logic [MINADDR_W-1:0] mem_r_addr;
  logic [MAXDATA_W-1:0] mem_r_data;

  fifo_pointers #(
    .W_DATA_W(W_DATA_W),
    .R_DATA_W(R_DATA_W),
    .ADDR_W  (ADDR_W)
  ) i_pointers (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .w_en_i   (w_en_i),
    .r_en_i   (r_en_i),
    .wr_go_o  (wr_go),
    .rd_go_o  (rd_go),
    .wr_addr_o(wr_addr),
    .rd_addr_o(rd_addr),
    .w_full_o (w_full_o),
    .r_empty_o(r_empty_o),
    .level_o  (level_o)
  );

  asym_converter #(
    .W_DATA_W(W_DATA_W),
    .R_DATA_W(R_DATA_W),
    .ADDR_W  (ADDR_W)
  ) i_converter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .w_en_i          (wr_go),
    .w_addr_i        (wr_addr),
    .w_data_i        (w_data_i),
    .r_en_i          (rd_go),
    .r_addr_i        (rd_addr),
    .ext_mem_w_en_o  (mem_w_en),
    .ext_mem_w_addr_o(mem_w_addr),
    .ext_mem_w_data_o(mem_w_data),
    .ext_mem_r_en_o  (mem_r_en),
    .ext_mem_r_addr_o(mem_r_addr),
    .ext_mem_r_data_i(mem_r_data),
    .r_data_o        (r_data_o)
  );

  banked_ram #(
    .W_DATA_W(W_DATA_W),
    .R_DATA_W(R_DATA_W),
    .ADDR_W  (ADDR_W)
  ) i_ram (
    .clk_i           (clk_i),
    .ext_mem_w_en_i  (mem_w_en),
    .ext_mem_w_addr_i(mem_w_addr),
    .ext_mem_w_data_i(mem_w_data),
    .ext_mem_r_en_i  (mem_r_en),
    .ext_mem_r_addr_i(mem_r_addr),
    .ext_mem_r_data_o(mem_r_data)
  );

endmodule

// File: bench/tb_asym_fifo_tasks.svh
`ifndef TB_ASYM_FIFO_TASKS_SVH
`define TB_ASYM_FIFO_TASKS_SVH

// compare one DUT output with its expected value
task automatic check_val(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
  assert (got === exp)
  else fail_now($sformatf("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got));
endtask

// flags and level follow from the model's byte count
task automatic check_outputs();
  int lvl;
  lvl = model_q.size();
  check_val("level_o", level, lvl);
  check_val("w_full_o", w_full, (DEPTH_UNITS - lvl) < UNITS_PER_WORD);
  check_val("r_empty_o", r_empty, lvl < 1);
  check_val("r_data_o", r_data, exp_rdata);
endtask

// one clock cycle, called and returning at a falling edge
task automatic step(input logic push_req, input logic [W_W-1:0] data, input logic pop_req);
  int lvl;
  logic push_ok;
  logic pop_ok;
  lvl = model_q.size();
  push_ok = push_req && ((DEPTH_UNITS - lvl) >= UNITS_PER_WORD);
  pop_ok = pop_req && (lvl >= 1);
  w_en = push_req;
  w_data = data;
  r_en = pop_req;
  @(posedge clk);
  @(negedge clk);
  // the pop sees only bytes stored before this edge
  if (pop_ok) begin
    exp_rdata = model_q.pop_front();
  end
  if (push_ok) begin
    for (int i = 0; i < UNITS_PER_WORD; i++) begin
      model_q.push_back(data[i*R_W +: R_W]);
    end
    push_count++;
  end
  w_en = 1'b0;
  r_en = 1'b0;
  check_outputs();
endtask

task automatic test_reset();
  check_val("r_empty_o", r_empty, 1'b1);
  check_val("w_full_o", w_full, 1'b0);
  check_val("level_o", level, 0);
  check_val("r_data_o", r_data, 0);
  step(1'b0, '0, 1'b0);
endtask

task automatic test_conversion();
  logic [W_W-1:0] word;
  word = 32'hd4c3b2a1;
  step(1'b1, word, 1'b0);
  check_val("level_o", level, UNITS_PER_WORD);
  for (int i = 0; i < UNITS_PER_WORD; i++) begin
    step(1'b0, '0, 1'b1);
    // least significant byte comes out first
    check_val("r_data_o", r_data, word[i*R_W +: R_W]);
    check_val("level_o", level, UNITS_PER_WORD - 1 - i);
  end
  // output holds the last byte while idle
  step(1'b0, '0, 1'b0);
  check_val("r_data_o", r_data, word[W_W-1 -: R_W]);
endtask

task automatic test_full();
  logic [W_W-1:0] words[N_WORDS];
  for (int i = 0; i < N_WORDS; i++) begin
    words[i] = $urandom;
    step(1'b1, words[i], 1'b0);
  end
  check_val("w_full_o", w_full, 1'b1);
  check_val("level_o", level, DEPTH_UNITS);
  // push against a full FIFO is dropped
  step(1'b1, 32'hdeadbeef, 1'b0);
  check_val("level_o", level, DEPTH_UNITS);
  for (int i = 0; i < DEPTH_UNITS; i++) begin
    step(1'b0, '0, 1'b1);
    check_val("r_data_o", r_data, words[i / UNITS_PER_WORD][(i % UNITS_PER_WORD)*R_W +: R_W]);
  end
  check_val("r_empty_o", r_empty, 1'b1);
endtask

task automatic test_empty();
  logic [R_W-1:0] last;
  last = exp_rdata;
  check_val("r_empty_o", r_empty, 1'b1);
  repeat (2) begin
    step(1'b0, '0, 1'b1);
    check_val("level_o", level, 0);
    check_val("r_empty_o", r_empty, 1'b1);
    check_val("r_data_o", r_data, last);
  end
endtask

task automatic test_random();
  logic push_req;
  logic pop_req;
  int start_pushes;
  int both_req;
  start_pushes = push_count;
  both_req = 0;
  for (int i = 0; i < RAND_CYCLES; i++) begin
    // first half leans toward filling, second half toward draining
    if (i < RAND_CYCLES / 2) begin
      push_req = ($urandom % 3) == 0;
      pop_req = ($urandom % 2) == 0;
    end else begin
      push_req = ($urandom % 8) == 0;
      pop_req = ($urandom % 8) != 0;
    end
    if (push_req && pop_req) begin
      both_req++;
    end
    step(push_req, $urandom, pop_req);
  end
  while (model_q.size() > 0) begin
    step(1'b0, '0, 1'b1);
  end
  assert (push_count - start_pushes >= 3 * N_WORDS)
  else fail_now("random traffic accepted too few pushes to wrap the pointers");
  assert (both_req > 0)
  else fail_now("random traffic never pushed and popped in the same cycle");
endtask

`endif

// File: bench/tb_asym_fifo.sv
`timescale 1ns/1ps

module tb_asym_fifo;

  localparam int W_W = 32;
  localparam int R_W = 8;
  localparam int A_W = 5;
  // read-side bytes per write word, and capacity in bytes
  localparam int UNITS_PER_WORD = W_W / R_W;
  localparam int DEPTH_UNITS = 1 << A_W;
  localparam int N_WORDS = DEPTH_UNITS / UNITS_PER_WORD;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] RAND_SEED = 32'h4cc2e4a1;
  localparam int RAND_CYCLES = 600;

  // cycles of reset, conversion, full, empty and random tests plus the final drain
  localparam int TEST_CYCLES = RESET_CYCLES + 1 + (UNITS_PER_WORD + 2)
                               + (N_WORDS + 1 + DEPTH_UNITS) + 2
                               + RAND_CYCLES + DEPTH_UNITS;

  logic clk;
  logic rst_n;
  logic w_en;
  logic [W_W-1:0] w_data;
  logic w_full;
  logic r_en;
  logic [R_W-1:0] r_data;
  logic r_empty;
  logic [A_W:0] level;

  // reference model with one entry per read-side byte and the oldest at the front
  logic [R_W-1:0] model_q[$];
  // byte that r_data must show after the last pop
  logic [R_W-1:0] exp_rdata;
  int push_count;

  asym_fifo #(
    .W_DATA_W(W_W),
    .R_DATA_W(R_W),
    .ADDR_W  (A_W)
  ) i_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .w_en_i   (w_en),
    .w_data_i (w_data),
    .w_full_o (w_full),
    .r_en_i   (r_en),
    .r_data_o (r_data),
    .r_empty_o(r_empty),
    .level_o  (level)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "tb_asym_fifo_tasks.svh"

  // watchdog fires after twice the expected length of the sequence
  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    fail_now("Timeout: the test sequence did not finish before the watchdog fired");
  end

  initial begin
    void'($urandom(RAND_SEED));
    rst_n = 1'b0;
    w_en = 1'b0;
    w_data = '0;
    r_en = 1'b0;
    exp_rdata = '0;
    push_count = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    test_conversion();
    test_full();
    test_empty();
    test_random();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
design/asym_fifo_pkg.sv
design/fifo_pointers.sv
design/asym_converter.sv
design/banked_ram.sv
design/asym_fifo.sv
bench/tb_asym_fifo.sv

// File: Bender.yml
package:
  name: asym_fifo

sources:
  # synthesizable design, package first
  - files:
      - design/asym_fifo_pkg.sv
      - design/fifo_pointers.sv
      - design/asym_converter.sv
      - design/banked_ram.sv
      - design/asym_fifo.sv

  # testbench, top module tb_asym_fifo
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_asym_fifo.sv
